// ==== filelist.f ====
+incdir+source
source/ifu_pkg.sv
source/ifu_fetch_ctl.sv
source/ifu_fb_credit.sv
source/ifu_fetch_buf.sv
source/ifu_aligner.sv
source/ifu_top.sv
sim/ifu_tb_clk.sv
sim/ifu_checker.sv
sim/ifu_properties.sv
sim/ifu_tb.sv

// ==== sim/ifu_checker.sv ====
// Decode port checker
`include "ifu_settings.svh"

module ifu_checker
   import ifu_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  logic   instr_valid,
   input  logic   instr_ready,
   input  instr_t instr,
   output int     seen_cnt,         // transfers taken so far
   output int     err_cnt           // wrong or extra transfers
);
   timeunit 1ns;
   timeprecision 1ps;

   instr_t exp_q  [$];              // expected instructions in order
   string  name_q [$];              // test name of each one

   initial begin
      seen_cnt = 0;
      err_cnt  = 0;
   end

   task automatic add_expected(input string name, input instr_t exp);
      name_q.push_back(name);
      exp_q.push_back(exp);
   endtask

   function automatic string format_instr(input instr_t i);
      return $sformatf("pc=%08h instr=%08h pc4=%0b fault=%0b",
                       {i.pc, 1'b0}, i.instr, i.pc4, i.fault);
   endfunction

   // **********************************************************************
   // compare every decode transfer with the next expected entry
   // **********************************************************************
   always @(posedge clk) begin
      if (rst_n && instr_valid && instr_ready) begin
         if (seen_cnt >= exp_q.size()) begin
            $display("unexpected instruction beyond the expected list: %s",
                     format_instr(instr));
            err_cnt <= err_cnt + 1;
         end else if (instr !== exp_q[seen_cnt]) begin
            $display("Fail %s: expected %s, actual %s", name_q[seen_cnt],
                     format_instr(exp_q[seen_cnt]), format_instr(instr));
            err_cnt <= err_cnt + 1;
         end
         seen_cnt <= seen_cnt + 1;
      end
   end

   // Instructions that never showed up by the end of the run
   function automatic int count_missing();
      int missing;
      missing = exp_q.size() - seen_cnt;
      if (missing > 0) begin
         $display("%0d expected instructions never arrived, the first is %s at pc %08h",
                  missing, name_q[seen_cnt], {exp_q[seen_cnt].pc, 1'b0});
         return missing;
      end
      return 0;
   endfunction

endmodule

// ==== sim/ifu_input.txt ====
# M <word addr> <64-bit data> [error flag]    F <flush pc>
# E <test> <pc> <instr> <pc4> <fault>
M 00000100 808200A000934501
M 00000108 2283050500B10113
M 00000110 8526418500010041
M 00000118 002085334611FFFF
M 00000120 0007A02307854705
M 00000128 DEADBEEF0BADF00D 1
M 00000130 0513333322221111
M 00000138 808245A145810050
M 00000140 0793000100010001
M 00000148 0000000000000000 1
E mixed 00000100 00004501 0 0
E mixed 00000102 00A00093 1 0
E mixed 00000106 00008082 0 0
E straddle 00000108 00B10113 1 0
E straddle 0000010C 00000505 0 0
E straddle 0000010E 00412283 1 0
E straddle 00000112 00000001 0 0
E straddle 00000114 00004185 0 0
E straddle 00000116 00008526 0 0
F 0000011A
E flush_mid 0000011A 00004611 0 0
E flush_mid 0000011C 00208533 1 0
E flush_mid 00000120 00004705 0 0
E flush_mid 00000122 00000785 0 0
E flush_mid 00000124 0007A023 1 0
E fault 00000128 00000000 0 1
F 00000136
E resume 00000136 00500513 1 0
E resume 0000013A 00004581 0 0
E resume 0000013C 000045A1 0 0
E resume 0000013E 00008082 0 0
F 00000146
E fault_straddle 00000146 00000000 0 1

// ==== sim/ifu_properties.sv ====
// Fetch unit bus properties
`include "ifu_settings.svh"

module ifu_properties
   import ifu_pkg::*;
(
   input logic                     clk,
   input logic                     rst_n,
   input flush_t                   flush,
   input logic                     ar_valid,
   input logic                     ar_ready,
   input ar_req_t                  ar,
   input logic                     r_valid,
   input logic                     r_ready,
   input logic                     instr_valid,
   input logic [`IFU_FB_CNT_W-1:0] credit_cnt   // reserved buffer slots
);
   timeunit 1ns;
   timeprecision 1ps;

   int   fail_cnt = 0;              // failed assertions
   logic rd_open;                   // read accepted, data not yet taken

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_open <= 1'b0;
      end else if (ar_valid && ar_ready) begin
         rd_open <= 1'b1;
      end else if (r_valid && r_ready) begin
         rd_open <= 1'b0;
      end
   end

   // **********************************************************************
   // bus and credit rules
   // **********************************************************************
   ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
      ar_valid && !ar_ready && !flush.valid |=> ar_valid && $stable(ar))
      else begin
         fail_cnt++;
         $error("read address changed or dropped before ar_ready");
      end

   // axi prot bit 2 marks an instruction access, fetch is 8B aligned
   ar_fetch: assert property (@(posedge clk) disable iff (!rst_n)
      ar_valid |-> ar.prot[2] && (ar.addr[2:0] == 3'b000))
      else begin
         fail_cnt++;
         $error("read address is not an aligned instruction fetch");
      end

   credit_max: assert property (@(posedge clk) disable iff (!rst_n)
      credit_cnt <= `IFU_FB_DEPTH)
      else begin
         fail_cnt++;
         $error("credit count %0d above buffer depth", credit_cnt);
      end

   reset_quiet: assert property (@(posedge clk)
      !rst_n |-> !instr_valid && !ar_valid)
      else begin
         fail_cnt++;
         $error("valid output raised during reset");
      end

   rsp_owned: assert property (@(posedge clk) disable iff (!rst_n)
      r_valid |-> rd_open)
      else begin
         fail_cnt++;
         $error("read response without an outstanding read");
      end

endmodule

// ==== sim/ifu_tb.sv ====
// Fetch unit testbench
`include "ifu_settings.svh"

module ifu_tb
   import ifu_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   logic    clk;
   logic    rst_n;
   flush_t  flush;
   logic    ar_valid;
   logic    ar_ready;
   ar_req_t ar;
   logic    r_valid;
   logic    r_ready;
   r_rsp_t  r;
   logic    instr_valid;
   logic    instr_ready;
   instr_t  instr;

   // memory image and schedule from the input file
   logic [`IFU_WORD_W-1:0] mem_data [logic [31:0]];
   logic                   mem_err  [logic [31:0]];
   int                     flush_at [$];        // instructions due before each flush
   logic [`IFU_PC_W-1:0]   flush_pc [$];
   int                     n_exp      = 0;
   int                     next_flush = 0;

   logic        rd_busy;                        // one read outstanding
   logic [31:0] rd_addr;
   int          rd_delay;

   int seed      = 44;
   int cycle_cnt = 0;
   int limit;
   int tb_errs   = 0;
   int seen_cnt;
   int chk_errs;

   ifu_tb_clk i_clk (
      .clk (clk)
   );

   ifu_top i_ifu_top (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush       (flush),
      .ar_valid    (ar_valid),
      .ar_ready    (ar_ready),
      .ar          (ar),
      .r_valid     (r_valid),
      .r_ready     (r_ready),
      .r           (r),
      .instr_valid (instr_valid),
      .instr_ready (instr_ready),
      .instr       (instr)
   );

   ifu_checker i_checker (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr_ready (instr_ready),
      .instr       (instr),
      .seen_cnt    (seen_cnt),
      .err_cnt     (chk_errs)
   );

   bind ifu_top ifu_properties i_props (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush       (flush),
      .ar_valid    (ar_valid),
      .ar_ready    (ar_ready),
      .ar          (ar),
      .r_valid     (r_valid),
      .r_ready     (r_ready),
      .instr_valid (instr_valid),
      .credit_cnt  (i_fb_credit.credit_cnt)
   );

   // unmapped words get a pattern built from the whole address
   function automatic logic [`IFU_WORD_W-1:0] read_word(input logic [31:0] addr);
      if (mem_data.exists(addr)) begin
         return mem_data[addr];
      end
      return {addr ^ 32'h5A5A_0F0F, ~addr};
   endfunction

   function automatic logic [1:0] read_resp(input logic [31:0] addr);
      if (mem_err.exists(addr) && mem_err[addr]) begin
         return 2'b10;                            // slverr
      end
      return `IFU_RESP_OKAY;
   endfunction

   // **********************************************************************
   // input file: M words, F flush points, E expected instructions
   // **********************************************************************
   task automatic load_input();
      int          fd;
      int          n;
      int          err;
      int          pc4;
      int          fault;
      string       line;
      string       kind;
      string       name;
      logic [31:0] addr;
      logic [63:0] data;
      logic [31:0] word;
      instr_t      exp;
      fd = $fopen("sim/ifu_input.txt", "r");
      if (fd == 0) begin
         $display("cannot open the input file sim/ifu_input.txt");
         tb_errs++;
         return;
      end
      while ($fgets(line, fd) > 0) begin
         n = $sscanf(line, "%s", kind);
         if (n < 1 || kind[0] == "#") begin
            continue;                             // blank or comment
         end
         case (kind)
            "M": begin
               err = 0;                           // flag column is optional
               n = $sscanf(line, "%s %h %h %d", kind, addr, data, err);
               mem_data[addr] = data;
               mem_err[addr]  = (err != 0);
            end
            "F": begin
               n = $sscanf(line, "%s %h", kind, addr);
               flush_at.push_back(n_exp);
               flush_pc.push_back(addr);
            end
            "E": begin
               n = $sscanf(line, "%s %s %h %h %d %d", kind, name, addr, word, pc4, fault);
               exp.pc    = addr[`IFU_PC_W-1:1];
               exp.instr = word;
               exp.pc4   = pc4[0];
               exp.fault = fault[0];
               i_checker.add_expected(name, exp);
               n_exp++;
            end
            default: begin
               $display("unknown line in the input file: %s", line);
               tb_errs++;
            end
         endcase
      end
      $fclose(fd);
   endtask

   // **********************************************************************
   // memory on the bus, decode back-pressure and flushes
   // **********************************************************************
   always @(posedge clk) begin : drive_inputs
      int total;                                  // transfers done after this edge
      if (!rst_n) begin
         ar_ready    <= 1'b0;
         r_valid     <= 1'b0;
         r           <= '0;
         rd_busy     <= 1'b0;
         instr_ready <= 1'b0;
         flush       <= '0;
      end else begin
         if (ar_valid && ar_ready) begin
            rd_busy  <= 1'b1;                     // latch the read
            rd_addr  <= ar.addr;
            rd_delay <= $random(seed) & 3;
            ar_ready <= 1'b0;
         end else if (!rd_busy) begin
            ar_ready <= ($random(seed) & 1) != 0;
         end
         if (r_valid && r_ready) begin
            r_valid <= 1'b0;
            rd_busy <= 1'b0;
         end else if (rd_busy && !r_valid) begin
            if (rd_delay == 0) begin
               r_valid <= 1'b1;
               r.data  <= read_word(rd_addr);
               r.resp  <= read_resp(rd_addr);
            end else begin
               rd_delay <= rd_delay - 1;
            end
         end
         total = seen_cnt + int'(instr_valid && instr_ready);
         flush <= '0;                             // one cycle pulse
         if (next_flush < flush_at.size() && total == flush_at[next_flush]) begin
            instr_ready <= 1'b0;                  // nothing taken past the flush point
            flush.valid <= 1'b1;
            flush.pc    <= flush_pc[next_flush][`IFU_PC_W-1:1];
            next_flush  <= next_flush + 1;
         end else begin
            instr_ready <= ($random(seed) & 3) != 0;
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   initial begin : main_flow
      int missing;
      int total_errs;
      rst_n       <= 1'b0;
      flush       <= '0;
      ar_ready    <= 1'b0;
      r_valid     <= 1'b0;
      r           <= '0;
      instr_ready <= 1'b0;
      load_input();
      limit = 100 * n_exp + 200;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      while (seen_cnt < n_exp && cycle_cnt < limit) begin
         @(posedge clk);
      end
      if (seen_cnt < n_exp) begin
         $display("timeout: only %0d of %0d instructions arrived within %0d cycles",
                  seen_cnt, n_exp, limit);
         tb_errs++;
      end
      repeat (10) @(posedge clk);                 // room for a stray transfer
      missing    = i_checker.count_missing();
      total_errs = tb_errs + chk_errs + missing + i_ifu_top.i_props.fail_cnt;
      $display("errors: %0d (checker %0d, missing %0d, assertions %0d, testbench %0d)",
               total_errs, chk_errs, missing, i_ifu_top.i_props.fail_cnt, tb_errs);
      if (total_errs == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== sim/ifu_tb_clk.sv ====
// Testbench clock
module ifu_tb_clk (
   output logic clk
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int PERIOD = 40;          // ns

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

endmodule

// ==== source/ifu_aligner.sv ====
// Instruction aligner
`include "ifu_settings.svh"

module ifu_aligner
   import ifu_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  flush_t    flush,
   input  logic      head_valid,
   input  fb_entry_t head,
   output logic      pop,          // last parcel of the head word used
   output logic      instr_valid,
   input  logic      instr_ready,
   output instr_t    instr
);

   localparam logic [`IFU_PC_W-1:0] RESET_PC = `IFU_RESET_PC;

   logic [1:0]               ptr, ptr_nxt;       // parcel index in head word
   logic [1:0]               ptr_p1, ptr_p2;
   logic                     carry_valid;        // low half of a straddling instr
   logic [`IFU_PARCEL_W-1:0] carry_parcel;
   logic [`IFU_PC_W-1:1]     carry_pc;
   logic                     halted;             // fault delivered, wait for flush
   logic [`IFU_PARCEL_W-1:0] p0, p1;             // current and following parcel
   logic                     step;               // work on the head this cycle
   logic                     emit;               // load the output register
   logic                     straddle;           // save last parcel as carry
   logic                     set_halt;
   instr_t                   instr_nxt;

   assign ptr_p1 = ptr + 2'd1;
   assign ptr_p2 = ptr + 2'd2;
   assign p0     = head.data[{ptr, 4'b0000} +: `IFU_PARCEL_W];
   assign p1     = head.data[{ptr_p1, 4'b0000} +: `IFU_PARCEL_W];
   assign step   = head_valid & ~halted & (~instr_valid | instr_ready);

   // **********************************************************************
   // parcel decode
   // **********************************************************************
   always_comb begin
      emit            = 1'b0;
      pop             = 1'b0;
      straddle        = 1'b0;
      set_halt        = 1'b0;
      ptr_nxt         = ptr;
      instr_nxt.pc    = {head.waddr, ptr};
      instr_nxt.instr = {{`IFU_PARCEL_W{1'b0}}, p0};   // 16-bit by default
      instr_nxt.pc4   = 1'b0;
      instr_nxt.fault = 1'b0;
      if (step) begin
         emit = 1'b1;
         if (head.fault) begin
            set_halt        = 1'b1;                      // one fault instr, then stop
            instr_nxt.instr = '0;
            instr_nxt.fault = 1'b1;
            if (carry_valid) begin
               instr_nxt.pc = carry_pc;
            end
         end else if (carry_valid) begin
            instr_nxt.pc    = carry_pc;                  // high half from new word
            instr_nxt.instr = {head.data[`IFU_PARCEL_W-1:0], carry_parcel};
            instr_nxt.pc4   = 1'b1;
            ptr_nxt         = 2'd1;
         end else if (p0[1:0] != 2'b11) begin
            ptr_nxt = ptr_p1;                            // compressed
            pop     = (ptr == 2'd3);
         end else if (ptr != 2'd3) begin
            instr_nxt.instr = {p1, p0};                  // both halves in this word
            instr_nxt.pc4   = 1'b1;
            ptr_nxt         = ptr_p2;
            pop             = (ptr == 2'd2);
         end else begin
            emit     = 1'b0;                             // wait for the next word
            straddle = 1'b1;
            ptr_nxt  = 2'd0;
            pop      = 1'b1;
         end
      end
   end

   // **********************************************************************
   // control state
   // **********************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr         <= RESET_PC[2:1];
         carry_valid <= 1'b0;
         halted      <= 1'b0;
         instr_valid <= 1'b0;
      end else if (flush.valid) begin
         ptr         <= flush.pc[2:1];                   // start mid-word
         carry_valid <= 1'b0;
         halted      <= 1'b0;
         instr_valid <= 1'b0;                            // withdraw stale instr
      end else begin
         ptr <= ptr_nxt;
         if (straddle) begin
            carry_valid <= 1'b1;
         end else if (step) begin
            carry_valid <= 1'b0;
         end
         if (set_halt) begin
            halted <= 1'b1;
         end
         if (emit) begin
            instr_valid <= 1'b1;
         end else if (instr_ready) begin
            instr_valid <= 1'b0;                         // taken by decode
         end
      end
   end

   // payload
   always_ff @(posedge clk) begin
      if (straddle) begin
         carry_parcel <= p0;
         carry_pc     <= {head.waddr, 2'b11};
      end
      if (emit) begin
         instr <= instr_nxt;
      end
   end

endmodule

// ==== source/ifu_fb_credit.sv ====
// Fetch buffer credits
`include "ifu_settings.svh"

module ifu_fb_credit
   import ifu_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        flush,
   input  credit_evt_t credit_evt,
   input  logic        slot_release,  // buffer entry popped by the aligner
   output logic        fb_space       // room for one more read
);

   logic [`IFU_FB_CNT_W-1:0] credit_cnt;      // slots reserved by issued reads
   logic [`IFU_FB_CNT_W-1:0] credit_cnt_nxt;

   always_comb begin
      credit_cnt_nxt = credit_cnt;
      if (credit_evt.issue) begin
         credit_cnt_nxt = credit_cnt_nxt + 1'b1;
      end
      if (slot_release) begin
         credit_cnt_nxt = credit_cnt_nxt - 1'b1;
      end
      if (credit_evt.discard) begin
         credit_cnt_nxt = credit_cnt_nxt - 1'b1;  // dropped response frees its slot
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         credit_cnt <= '0;
      end else if (flush) begin
         // buffer is emptied, only a live read keeps its slot
         credit_cnt <= {{(`IFU_FB_CNT_W-1){1'b0}}, credit_evt.pending};
      end else begin
         credit_cnt <= credit_cnt_nxt;
      end
   end

   assign fb_space = (credit_cnt < `IFU_FB_DEPTH);  // never full when data lands

endmodule

// ==== source/ifu_fetch_buf.sv ====
// Fetch buffer FIFO
`include "ifu_settings.svh"

module ifu_fetch_buf
   import ifu_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      flush,        // empties the buffer
   input  logic      push,
   input  fb_entry_t push_entry,
   input  logic      pop,          // head word fully used
   output logic      head_valid,
   output fb_entry_t head
);

   // pointers carry one extra wrap bit
   logic [`IFU_FB_PTR_W:0] wr_ptr;
   logic [`IFU_FB_PTR_W:0] rd_ptr;

   fb_entry_t mem [`IFU_FB_DEPTH];  // word storage

   // **********************************************************************
   // storage
   // **********************************************************************
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr[`IFU_FB_PTR_W-1:0]] <= push_entry;
      end
   end

   // **********************************************************************
   // pointers
   // **********************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else if (flush) begin
         wr_ptr <= '0;                    // everything fetched is stale
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;      // credits keep this from overflowing
         end
         if (pop && head_valid) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   assign head_valid = (wr_ptr != rd_ptr);                 // valid one cycle after push
   assign head       = mem[rd_ptr[`IFU_FB_PTR_W-1:0]];

endmodule

// ==== source/ifu_fetch_ctl.sv ====
// Fetch address controller
`include "ifu_settings.svh"

module ifu_fetch_ctl
   import ifu_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  flush_t      flush,        // redirect from the core
   output logic        ar_valid,
   input  logic        ar_ready,
   output ar_req_t     ar,
   input  logic        r_valid,
   output logic        r_ready,
   input  r_rsp_t      r,
   input  logic        fb_space,     // a buffer slot can be reserved
   output credit_evt_t credit_evt,
   output logic        push,         // write a word into the fetch buffer
   output fb_entry_t   push_entry
);

   localparam logic [`IFU_PC_W-1:0] RESET_PC = `IFU_RESET_PC;

   fetch_state_e         state, state_nxt;
   logic [`IFU_PC_W-1:3] waddr, waddr_nxt;  // next word to fetch
   logic                 ar_hs;             // address handshake this cycle
   logic                 r_hs;              // response accepted this cycle

   assign ar_hs    = ar_valid & ar_ready;
   assign r_hs     = r_valid & r_ready;

   assign ar_valid = (state == REQ) & fb_space;  // held by credits until accepted
   assign ar.addr  = {waddr, 3'b000};
   assign ar.prot  = `IFU_AR_PROT;
   assign r_ready  = (state == WAIT) | (state == DRAIN);

   // response goes to the buffer unless a flush makes it stale
   assign push             = (state == WAIT) & r_hs & ~flush.valid;
   assign push_entry.waddr = waddr;
   assign push_entry.data  = r.data;
   assign push_entry.fault = (r.resp != `IFU_RESP_OKAY);

   assign credit_evt.issue   = ar_hs & ~flush.valid;
   assign credit_evt.discard = (state == DRAIN) & r_hs;
   // a read survives this edge when it is unanswered or just issued
   assign credit_evt.pending = (r_ready & ~r_valid) | ar_hs;

   // **********************************************************************
   // state machine
   // **********************************************************************
   always_comb begin
      state_nxt = state;
      waddr_nxt = waddr;
      if (flush.valid) begin
         waddr_nxt = flush.pc[`IFU_PC_W-1:3];                   // drop bits 2:1
         state_nxt = credit_evt.pending ? DRAIN : REQ;          // wait out a live read
      end else begin
         case (state)
            IDLE:    state_nxt = REQ;
            REQ:     if (ar_hs) state_nxt = WAIT;
            WAIT: begin
               if (r_hs) begin
                  waddr_nxt = waddr + 1'b1;                     // next 8 bytes
                  state_nxt = push_entry.fault ? HALT : REQ;
               end
            end
            DRAIN:   if (r_hs) state_nxt = REQ;                 // stale data dropped
            HALT:    state_nxt = HALT;                          // only a flush leaves
            default: state_nxt = IDLE;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
         waddr <= RESET_PC[`IFU_PC_W-1:3];
      end else begin
         state <= state_nxt;
         waddr <= waddr_nxt;
      end
   end

endmodule

// ==== source/ifu_pkg.sv ====
// Fetch unit types
`include "ifu_settings.svh"

package ifu_pkg;

   // fetch controller states
   typedef enum logic [2:0] {
      IDLE  = 3'd0,                  // out of reset
      REQ   = 3'd1,                  // drive read address
      WAIT  = 3'd2,                  // wait for read data
      DRAIN = 3'd3,                  // drop a response made stale by flush
      HALT  = 3'd4                   // access fault seen, wait for flush
   } fetch_state_e;

   typedef struct packed {
      logic [`IFU_PC_W-1:0]   addr;  // 8B aligned word address
      logic [2:0]             prot;
   } ar_req_t;

   typedef struct packed {
      logic [`IFU_WORD_W-1:0] data;
      logic [1:0]             resp;
   } r_rsp_t;

   typedef struct packed {
      logic                   valid;
      logic [`IFU_PC_W-1:1]   pc;    // redirect target
   } flush_t;

   typedef struct packed {
      logic [`IFU_PC_W-1:3]   waddr; // word address of the data
      logic [`IFU_WORD_W-1:0] data;
      logic                   fault; // bus error on this word
   } fb_entry_t;

   typedef struct packed {
      logic issue;                   // read address accepted
      logic discard;                 // stale response dropped
      logic pending;                 // read still outstanding
   } credit_evt_t;

   typedef struct packed {
      logic [`IFU_PC_W-1:1]   pc;
      logic [31:0]            instr; // upper half zero when 16-bit
      logic                   pc4;   // 32-bit instruction
      logic                   fault; // access fault
   } instr_t;

endpackage

// ==== source/ifu_settings.svh ====
// Fetch unit settings
`ifndef IFU_SETTINGS_SVH
`define IFU_SETTINGS_SVH

// **********************************************************************
// widths of the fetch path
// **********************************************************************
`define IFU_PC_W      32             // byte pc width, bit 0 not carried
`define IFU_WORD_W    64             // bus data width, four parcels
`define IFU_PARCEL_W  16             // one compressed parcel

// **********************************************************************
// fetch buffer and bus constants
// **********************************************************************
`define IFU_FB_DEPTH  4              // fetch buffer entries
`define IFU_FB_PTR_W  2              // log2 of the depth
`define IFU_FB_CNT_W  3              // credit count, 0 .. depth

`define IFU_RESET_PC  32'h0000_0100  // first fetch after reset
`define IFU_RESP_OKAY 2'b00          // axi rresp okay
`define IFU_AR_PROT   3'b100         // instruction, secure, unprivileged

`endif

// ==== source/ifu_top.sv ====
// Instruction fetch unit
module ifu_top
   import ifu_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  flush_t  flush,        // redirect from the core

   // axi read address channel
   output logic    ar_valid,
   input  logic    ar_ready,
   output ar_req_t ar,

   // axi read data channel
   input  logic    r_valid,
   output logic    r_ready,
   input  r_rsp_t  r,

   // decode
   output logic    instr_valid,
   input  logic    instr_ready,
   output instr_t  instr
);

   credit_evt_t credit_evt;     // controller events to the credit counter
   logic        fb_space;
   logic        push;
   fb_entry_t   push_entry;
   logic        head_valid;
   fb_entry_t   head;
   logic        pop;            // also releases a credit

   // **********************************************************************
   // fetch path
   // **********************************************************************
   ifu_fetch_ctl i_fetch_ctl (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush),
      .ar_valid   (ar_valid),
      .ar_ready   (ar_ready),
      .ar         (ar),
      .r_valid    (r_valid),
      .r_ready    (r_ready),
      .r          (r),
      .fb_space   (fb_space),
      .credit_evt (credit_evt),
      .push       (push),
      .push_entry (push_entry)
   );

   ifu_fb_credit i_fb_credit (
      .clk          (clk),
      .rst_n        (rst_n),
      .flush        (flush.valid),
      .credit_evt   (credit_evt),
      .slot_release (pop),
      .fb_space     (fb_space)
   );

   ifu_fetch_buf i_fetch_buf (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush.valid),
      .push       (push),
      .push_entry (push_entry),
      .pop        (pop),
      .head_valid (head_valid),
      .head       (head)
   );

   ifu_aligner i_aligner (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush       (flush),
      .head_valid  (head_valid),
      .head        (head),
      .pop         (pop),
      .instr_valid (instr_valid),
      .instr_ready (instr_ready),
      .instr       (instr)
   );

endmodule
